//--- Makefile
VERILATOR ?= verilator
TOP ?= rob_tb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only -Wall --top-module rob_top design/rob_pkg.sv \
		design/rob_dispatch.sv design/rob_slot.sv design/rob_retire.sv design/rob_top.sv

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; true
	cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation did not finish"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/rob_dispatch.sv
module rob_dispatch (
	input  logic clock,
	input  logic reset,
	input  logic flush,
	input  rob_pkg::dispatch_packet_t [rob_pkg::lanes-1:0] dispatch,
	input  logic [1:0] retire_count,
	output rob_pkg::dispatch_packet_t [rob_pkg::lanes-1:0] alloc,
	output rob_pkg::rob_index_t [rob_pkg::lanes-1:0] alloc_index,
	output rob_pkg::lane_mask_t struct_stall
);
	import rob_pkg::*;

	rob_index_t tail;
	logic [count_width-1:0] count;
	logic [count_width-1:0] free;
	lane_mask_t accepted;
	logic [1:0] accept_count;

	// free space as seen at the start of the cycle.
	assign free = count_width'(rob_depth) - count;

	////////////////////////////////////////////////////////////
	// lane acceptance
	////////////////////////////////////////////////////////////

	// lane i needs i+1 free entries, so the stall mask grows down from lane 2.
	always_comb begin
		accept_count = '0;
		for (int i = 0; i < lanes; i++) begin
			struct_stall[i] = (free <= count_width'(i));
			accepted[i] = dispatch[i].valid && !struct_stall[i];
			alloc[i].valid = accepted[i];
			alloc[i].entry = dispatch[i].entry;
			if (accepted[i]) begin
				alloc_index[i] = tail + rob_index_t'(i); // wraps at rob_depth.
			end else begin
				alloc_index[i] = '0;
			end
			accept_count = accept_count + 2'(accepted[i]);
		end
	end

	////////////////////////////////////////////////////////////
	// tail and occupancy
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			tail <= '0;
			count <= '0;
		end else begin
			tail <= tail + rob_index_t'(accept_count);
			count <= count + count_width'(accept_count) - count_width'(retire_count);
		end
	end

endmodule

//--- design/rob_pkg.sv
package rob_pkg;

	////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////

	localparam int xlen = 32; // pc width.
	localparam int rob_depth = 32;
	localparam int rob_index_width = 5;
	localparam int lanes = 3; // dispatch, completion and retire width.
	localparam int arch_reg_width = 5;
	localparam int phys_tag_width = 6;
	localparam int count_width = 6; // occupancy runs from 0 to rob_depth.

	////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		op_alu,
		op_load,
		op_store,
		op_branch
	} op_kind_t;

	typedef logic [rob_index_width-1:0] rob_index_t;
	typedef logic [lanes-1:0] lane_mask_t;

	// the instruction as it arrives from dispatch.
	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [arch_reg_width-1:0] dest;
		logic [phys_tag_width-1:0] tag;
		op_kind_t kind;
	} rob_entry_t;

	typedef struct packed {
		logic valid;
		rob_entry_t entry;
	} dispatch_packet_t;

	typedef struct packed {
		logic valid;
		rob_index_t index; // entry that finished execution.
		logic mispredict;
		logic [xlen-1:0] target_pc;
	} complete_packet_t;

	// what one slot shows the retire unit.
	typedef struct packed {
		logic valid;
		logic completed;
		rob_entry_t entry;
		logic mispredict;
		logic [xlen-1:0] target_pc;
	} slot_state_t;

	typedef struct packed {
		logic valid;
		rob_entry_t entry;
		logic mispredict;
		logic [xlen-1:0] target_pc;
	} retire_packet_t;

endpackage

//--- design/rob_retire.sv
module rob_retire (
	input  logic clock,
	input  logic reset,
	input  logic flush,
	input  rob_pkg::slot_state_t [rob_pkg::rob_depth-1:0] slots,
	input  logic store_stall,
	output rob_pkg::retire_packet_t [rob_pkg::lanes-1:0] retire,
	output logic [1:0] retire_count,
	output logic [rob_pkg::rob_depth-1:0] clear
);
	import rob_pkg::*;

	rob_index_t head;
	rob_index_t [lanes-1:0] lane_index;
	slot_state_t [lanes-1:0] candidate;
	lane_mask_t ready;
	lane_mask_t go;

	////////////////////////////////////////////////////////////
	// candidates from the head
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < lanes; i++) begin
			lane_index[i] = head + rob_index_t'(i);
			candidate[i] = slots[lane_index[i]];
			// a store waits at the head while the store queue holds it back.
			ready[i] = candidate[i].valid && candidate[i].completed &&
				!(store_stall && (candidate[i].entry.kind == op_store));
		end
	end

	// the first entry that is not ready ends the run for this cycle.
	always_comb begin
		logic run;
		run = 1'b1;
		retire_count = '0;
		clear = '0;
		for (int i = 0; i < lanes; i++) begin
			run = run && ready[i];
			go[i] = run;
			retire[i] = '0;
			if (go[i]) begin
				retire[i].valid = 1'b1;
				retire[i].entry = candidate[i].entry;
				retire[i].mispredict = candidate[i].mispredict;
				retire[i].target_pc = candidate[i].target_pc;
				clear[lane_index[i]] = 1'b1;
			end
			retire_count = retire_count + 2'(go[i]);
		end
	end

	////////////////////////////////////////////////////////////
	// head pointer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			head <= '0;
		end else begin
			head <= head + rob_index_t'(retire_count); // wraps at rob_depth.
		end
	end

endmodule

//--- design/rob_slot.sv
module rob_slot #(
	parameter int unsigned slot_index = 0
) (
	input  logic clock,
	input  logic reset,
	input  logic flush,
	input  rob_pkg::dispatch_packet_t [rob_pkg::lanes-1:0] alloc,
	input  rob_pkg::rob_index_t [rob_pkg::lanes-1:0] alloc_index,
	input  rob_pkg::complete_packet_t [rob_pkg::lanes-1:0] complete,
	input  logic clear,
	output rob_pkg::slot_state_t state
);
	import rob_pkg::*;

	logic valid;
	logic completed;
	logic mispredict;
	rob_entry_t entry;
	logic [xlen-1:0] target_pc;
	lane_mask_t alloc_hit;
	lane_mask_t complete_hit;

	always_comb begin
		for (int i = 0; i < lanes; i++) begin
			alloc_hit[i] = alloc[i].valid && (alloc_index[i] == rob_index_t'(slot_index));
			complete_hit[i] = complete[i].valid && (complete[i].index == rob_index_t'(slot_index));
		end
	end

	// a retiring slot cannot be reallocated in the same cycle, free space excludes it.
	always_ff @(posedge clock) begin
		if (reset || flush) begin
			valid <= 1'b0;
			completed <= 1'b0;
		end else if (clear) begin
			valid <= 1'b0;
			completed <= 1'b0;
		end else begin
			if (|alloc_hit) begin
				valid <= 1'b1;
				completed <= 1'b0;
			end
			if (|complete_hit) completed <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < lanes; i++) begin
			if (alloc_hit[i]) begin
				entry <= alloc[i].entry;
				mispredict <= 1'b0;
				target_pc <= '0;
			end
			if (complete_hit[i]) begin
				mispredict <= complete[i].mispredict;
				target_pc <= complete[i].mispredict ? complete[i].target_pc : '0;
			end
		end
	end

	assign state.valid = valid;
	assign state.completed = completed;
	assign state.entry = entry;
	assign state.mispredict = mispredict;
	assign state.target_pc = target_pc;

endmodule

//--- design/rob_top.sv
module rob_top (
	input  logic clock,
	input  logic reset,
	input  rob_pkg::dispatch_packet_t [rob_pkg::lanes-1:0] dispatch,
	input  rob_pkg::complete_packet_t [rob_pkg::lanes-1:0] complete,
	input  logic store_stall,
	input  logic flush,
	output rob_pkg::rob_index_t [rob_pkg::lanes-1:0] dispatch_index,
	output rob_pkg::lane_mask_t struct_stall,
	output rob_pkg::retire_packet_t [rob_pkg::lanes-1:0] retire
);
	import rob_pkg::*;

	dispatch_packet_t [lanes-1:0] alloc;
	logic [1:0] retire_count;
	slot_state_t [rob_depth-1:0] slots;
	logic [rob_depth-1:0] clear;

	// the allocation indices go out unchanged as the dispatch indices.
	rob_dispatch dispatch_i (
		.clock(clock),
		.reset(reset),
		.flush(flush),
		.dispatch(dispatch),
		.retire_count(retire_count),
		.alloc(alloc),
		.alloc_index(dispatch_index),
		.struct_stall(struct_stall)
	);

	for (genvar s = 0; s < rob_depth; s++) begin : g_slot
		rob_slot #(
			.slot_index(s)
		) slot_i (
			.clock(clock),
			.reset(reset),
			.flush(flush),
			.alloc(alloc),
			.alloc_index(dispatch_index),
			.complete(complete),
			.clear(clear[s]),
			.state(slots[s])
		);
	end

	rob_retire retire_i (
		.clock(clock),
		.reset(reset),
		.flush(flush),
		.slots(slots),
		.store_stall(store_stall),
		.retire(retire),
		.retire_count(retire_count),
		.clear(clear)
	);

endmodule

//--- tb.f
design/rob_pkg.sv
design/rob_dispatch.sv
design/rob_slot.sv
design/rob_retire.sv
design/rob_top.sv
testbench/rob_properties.sv
testbench/rob_tb.sv

//--- testbench/rob_properties.sv
module rob_properties (
	input logic clock,
	input logic reset,
	input logic flush,
	input rob_pkg::rob_index_t [rob_pkg::lanes-1:0] dispatch_index,
	input rob_pkg::lane_mask_t struct_stall,
	input rob_pkg::retire_packet_t [rob_pkg::lanes-1:0] retire
);
	import rob_pkg::*;

	// retirement is in order, so a gap in the valids is never legal.
	assert property (@(posedge clock) disable iff (reset)
		!(retire[1].valid && !retire[0].valid) && !(retire[2].valid && !retire[1].valid))
		else $error("retire valids are not contiguous from lane 0.");

	assert property (@(posedge clock) (reset || flush) |=>
		!(retire[0].valid || retire[1].valid || retire[2].valid))
		else $error("retire valid in the cycle after reset or flush.");

	for (genvar i = 0; i < lanes; i++) begin : g_lane
		assert property (@(posedge clock) disable iff (reset)
			struct_stall[i] |-> (dispatch_index[i] == '0))
			else $error("stalled lane %0d has a nonzero dispatch index.", i);
	end

endmodule

//--- testbench/rob_tb.sv
module rob_tb;
	import rob_pkg::*;

	// one entry of the reference model, kept in program order.
	typedef struct packed {
		rob_index_t idx;
		rob_entry_t entry;
		logic done;
		logic mis;
		logic [xlen-1:0] tgt;
	} model_entry_t;

	typedef struct packed {
		logic [1:0] n_disp;
		logic force_store; // lane 0 becomes a store.
		lane_mask_t comp_valid;
		rob_index_t [lanes-1:0] comp_idx;
		lane_mask_t mis;
		logic stall;
		logic flush;
	} step_t;

	logic clock;
	logic reset;
	logic store_stall;
	logic flush;
	dispatch_packet_t [lanes-1:0] dispatch;
	complete_packet_t [lanes-1:0] complete;
	rob_index_t [lanes-1:0] dispatch_index;
	lane_mask_t struct_stall;
	retire_packet_t [lanes-1:0] retire;

	step_t steps[$];
	model_entry_t model[$];
	rob_index_t model_tail;
	int seed = 32416;
	int errors = 0;
	int checks = 0;

	rob_top dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial begin
		repeat (2000) @(posedge clock);
		$display("timeout: the run did not finish within 2000 cycles");
		$display("ERRORS FOUND");
		$finish;
	end

	function automatic logic [xlen-1:0] target_for(rob_index_t idx);
		return 32'h8000_0000 | {idx, 2'b00};
	endfunction

	task automatic add_step(int n, bit fs, lane_mask_t cv, rob_index_t c0, rob_index_t c1,
			rob_index_t c2, lane_mask_t mis, bit stall, bit fl);
		step_t st;
		st.n_disp = 2'(n);
		st.force_store = fs;
		st.comp_valid = cv;
		st.comp_idx = {c2, c1, c0};
		st.mis = mis;
		st.stall = stall;
		st.flush = fl;
		steps.push_back(st);
	endtask

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_index(int lane, rob_index_t got, rob_index_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: dispatch_index[%0d] is %0d, expected %0d",
				$time, lane, got, exp);
		end
	endtask

	task automatic check_stall(lane_mask_t got, lane_mask_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: struct_stall is %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic check_retire(int lane, retire_packet_t got, retire_packet_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: retire[%0d] is %h, expected %h", $time, lane, got, exp);
		end
	endtask

	task automatic apply_step(step_t st, int num);
		rob_entry_t e;
		model_entry_t m;
		retire_packet_t exp_ret;
		lane_mask_t exp_stall;
		rob_index_t exp_idx;
		int free;
		int acc;
		int nret;
		int errs_before;
		bit run;
		errs_before = errors;
		for (int i = 0; i < lanes; i++) begin
			e.pc = $random(seed);
			e.dest = 5'($random(seed));
			e.tag = 6'($random(seed));
			e.kind = op_kind_t'(2'($random(seed)));
			if (st.force_store && i == 0) e.kind = op_store;
			dispatch[i].valid = (i < st.n_disp);
			dispatch[i].entry = e;
			complete[i].valid = st.comp_valid[i];
			complete[i].index = st.comp_idx[i];
			complete[i].mispredict = st.mis[i];
			complete[i].target_pc = target_for(st.comp_idx[i]);
		end
		store_stall = st.stall;
		flush = st.flush;
		#2;
		free = rob_depth - model.size();
		acc = 0;
		for (int i = 0; i < lanes; i++) begin
			exp_stall[i] = (free <= i);
			exp_idx = '0;
			if (dispatch[i].valid && !exp_stall[i]) begin
				exp_idx = model_tail + rob_index_t'(i);
				acc++;
			end
			check_index(i, dispatch_index[i], exp_idx);
		end
		check_stall(struct_stall, exp_stall);
		run = 1'b1;
		nret = 0;
		for (int i = 0; i < lanes; i++) begin
			exp_ret = '0;
			run = run && (i < model.size());
			if (run) run = model[i].done && !(st.stall && model[i].entry.kind == op_store);
			if (run) begin
				exp_ret.valid = 1'b1;
				exp_ret.entry = model[i].entry;
				exp_ret.mispredict = model[i].mis;
				exp_ret.target_pc = model[i].tgt;
				nret++;
			end
			check_retire(i, retire[i], exp_ret);
		end
		@(posedge clock);
		if (st.flush) begin
			model.delete();
			model_tail = '0;
		end else begin
			repeat (nret) void'(model.pop_front()); // clear wins over a late completion.
			for (int i = 0; i < lanes; i++) begin
				foreach (model[j]) begin
					if (st.comp_valid[i] && model[j].idx == st.comp_idx[i]) begin
						model[j].done = 1'b1;
						model[j].mis = st.mis[i];
						model[j].tgt = st.mis[i] ? target_for(st.comp_idx[i]) : '0;
					end
				end
			end
			for (int i = 0; i < acc; i++) begin
				m = '0;
				m.idx = model_tail + rob_index_t'(i);
				m.entry = dispatch[i].entry;
				model.push_back(m);
			end
			model_tail = model_tail + rob_index_t'(acc);
		end
		@(negedge clock);
		$display("step %0d finished with %0d mismatches", num, errors - errs_before);
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (retire[0].valid && n < 20) begin
			@(negedge clock);
			n++;
		end
		if (retire[0].valid) begin
			errors++;
			$display("timeout: the retire lanes never went idle");
		end
	endtask

	initial begin
		reset = 1'b1;
		flush = 1'b0;
		store_stall = 1'b0;
		dispatch = '0;
		complete = '0;
		model_tail = '0;
		add_step(3, 0, 3'b000, 0, 0, 0, 3'b000, 0, 0);
		add_step(3, 0, 3'b011, 2, 1, 0, 3'b000, 0, 0); // completions out of order.
		add_step(0, 0, 3'b001, 0, 0, 0, 3'b001, 0, 0);
		add_step(0, 0, 3'b011, 5, 3, 0, 3'b000, 0, 0);
		add_step(0, 0, 3'b001, 4, 0, 0, 3'b000, 0, 0);
		add_step(0, 0, 3'b000, 0, 0, 0, 3'b000, 0, 0);
		add_step(0, 0, 3'b000, 0, 0, 0, 3'b000, 0, 0);
		for (int k = 0; k < 10; k++) add_step(3, 0, 3'b000, 0, 0, 0, 3'b000, 0, 0);
		add_step(1, 0, 3'b000, 0, 0, 0, 3'b000, 0, 0);
		add_step(3, 0, 3'b000, 0, 0, 0, 3'b000, 0, 0); // one entry left for lane 0.
		add_step(3, 0, 3'b111, 6, 7, 8, 3'b000, 0, 0); // the buffer is full and every lane stalls.
		add_step(3, 0, 3'b000, 0, 0, 0, 3'b000, 0, 0);
		add_step(3, 0, 3'b111, 0, 1, 2, 3'b000, 0, 0); // completed entries behind the head.
		add_step(0, 0, 3'b000, 0, 0, 0, 3'b000, 0, 1);
		add_step(3, 1, 3'b000, 0, 0, 0, 3'b000, 1, 0);
		add_step(0, 0, 3'b111, 0, 1, 2, 3'b010, 1, 0);
		add_step(0, 0, 3'b000, 0, 0, 0, 3'b000, 1, 0);
		add_step(0, 0, 3'b000, 0, 0, 0, 3'b000, 1, 0);
		add_step(0, 0, 3'b000, 0, 0, 0, 3'b000, 0, 0);
		add_step(0, 0, 3'b000, 0, 0, 0, 3'b000, 0, 0);
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		foreach (steps[s]) apply_step(steps[s], s);
		wait_idle();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	bind rob_top rob_properties props_i (
		.clock(clock),
		.reset(reset),
		.flush(flush),
		.dispatch_index(dispatch_index),
		.struct_stall(struct_stall),
		.retire(retire)
	);

endmodule
